// ==== Makefile ====
SIM      = verilator
TOP      = mcp_control_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+design
+incdir+bench
design/mcp_pkg.sv
design/mcp_decode.sv
design/mcp_translate.sv
design/mcp_sequencer.sv
design/mcp_bus_ctl.sv
design/mcp_control.sv
bench/mcp_control_tb.sv

// ==== bench/mcp_control_tb_util.svh ====
`ifndef MCP_CONTROL_TB_UTIL_SVH
`define MCP_CONTROL_TB_UTIL_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// wait length in ticks, 1..8
task automatic draw_hold(output int n);
   logic [2:0] v;
   v = '0;
   for (int b = 0; b < 3; b++)
   begin
      lfsr = lfsr_step(lfsr);               // one step per bit
      v    = {v[1:0], lfsr[0]};
   end
   n = int'(v) + 1;
endtask

task automatic stop_on_error(input string what);
   $display("%s", what);
   $display("Testbench failed");
   $fatal(1);
endtask

task automatic compare_addr(input string name, input mcp_pkg::mcp_addr_t exp,
                            input mcp_pkg::mcp_addr_t act);
   if (act !== exp)
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
endtask

task automatic compare_bus(input string name, input mcp_pkg::mcp_bus_t exp,
                           input mcp_pkg::mcp_bus_t act);
   if (act !== exp)
      stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
      stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
endtask

// wi is combinational, it should drop right after release
task automatic wait_wi_low(input int row);
   int cnt;
   cnt = 0;
   do
   begin
      step_cycle();
      cnt++;
   end
   while (pin_bus.wi !== 1'b0 && cnt < WAIT_LIMIT);
   if (pin_bus.wi !== 1'b0)
      stop_on_error($sformatf("wait stayed high after release in row %0d", row));
endtask

`endif

// ==== bench/mcp_control_tb.sv ====
`timescale 1ns/1ps
`include "mcp_params.svh"

module mcp_control_tb;

localparam logic [31:0] SEED       = 32'h2d4b_3acd;
localparam int          WAIT_LIMIT = 16;      // cycles after release
localparam logic [1:0]  WK_NONE    = 2'd0;
localparam logic [1:0]  WK_READY   = 2'd1;    // ra held low
localparam logic [1:0]  WK_BUSY    = 2'd2;    // bbusy held high
localparam int          N_ROWS     = 32;

typedef struct packed
{
   mcp_pkg::mcp_mi_t   mi;       // loaded on the row's tick
   logic               cond;     // inputs during execution
   logic               ra;
   logic               bbusy;
   logic [4:1]         rq;
   logic               srn;
   logic [1:0]         wk;       // wait kind
   mcp_pkg::mcp_addr_t exp_lc;   // next address
   logic               exp_nop;
   mcp_pkg::mcp_bus_t  exp_bus;  // syn di dout inrak wrby wi
} row_t;

// mi {rni, call, op, field}, cond ra bbusy rq srn wk, lc nop bus
localparam row_t ROWS [N_ROWS] = '{
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h002, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::JUMP,       12'h040}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h040, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::JUMP_LOW,   12'h0a5}, 1'b1, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h0a5, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::JUMP_LOW,   12'h033}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h0a6, 1'b0, 6'b000000},
'{'{1'b0, 1'b1, mcp_pkg::JUMP,       12'h200}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h200, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h201, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::RETURN,     12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h0a7, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::LOAD_TR,    12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h0a8, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'hc00}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h0a9, 1'b0, 6'b000000},
'{'{1'b1, 1'b0, mcp_pkg::DISPATCH,   12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h603, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::DISPATCH,   12'h000}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h604, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::SET_FLAG,   12'h006}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h605, 1'b0, 6'b000000},
'{'{1'b1, 1'b0, mcp_pkg::DISPATCH,   12'h000}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h01c, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::CLR_FLAG,   12'h006}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h01d, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::CLR_STATUS, 12'h000}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h01e, 1'b0, 6'b000000},
'{'{1'b1, 1'b0, mcp_pkg::DISPATCH,   12'h000}, 1'b0, 1'b1, 1'b0, 4'h2, 1'b1, WK_NONE,
  11'h014, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::CLR_STATUS, 12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h015, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::READ,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h016, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h017, 1'b0, 6'b100000},
'{'{1'b0, 1'b0, mcp_pkg::END_CYCLE,  12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_READY,
  11'h018, 1'b0, 6'b100000},
'{'{1'b0, 1'b0, mcp_pkg::WRITE_BYTE, 12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h019, 1'b0, 6'b000010},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h01a, 1'b0, 6'b101010},
'{'{1'b0, 1'b0, mcp_pkg::END_CYCLE,  12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h01b, 1'b0, 6'b101000},
'{'{1'b0, 1'b0, mcp_pkg::IACK,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h01c, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h01d, 1'b0, 6'b000100},
'{'{1'b0, 1'b0, mcp_pkg::END_CYCLE,  12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h01e, 1'b0, 6'b000100},
'{'{1'b0, 1'b0, mcp_pkg::READ,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_BUSY,
  11'h01f, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h020, 1'b0, 6'b100000},
'{'{1'b0, 1'b0, mcp_pkg::END_CYCLE,  12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h021, 1'b0, 6'b110000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b0, WK_NONE,
  11'h022, 1'b0, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h001, 1'b1, 6'b000000},
'{'{1'b0, 1'b0, mcp_pkg::NEXT,       12'h000}, 1'b0, 1'b1, 1'b0, 4'h0, 1'b1, WK_NONE,
  11'h002, 1'b0, 6'b000000}
};

logic                pin_clk;
logic                arst_n;
logic                pin_c1;
logic                pin_c4;
logic                pin_cond;
logic [17:0]         pin_mi;
logic [4:1]          pin_inrrq;
logic                pin_bbusy;
logic                pin_sr_n;
logic                pin_ra;
mcp_pkg::mcp_addr_t  pin_lc;
logic                pin_nop;
mcp_pkg::mcp_bus_t   pin_bus;
logic [31:0]         lfsr;      // stimulus random state
int                  phase;     // 0 marks the c1 cycle

mcp_control i_mcp_control
(
   .pin_clk   (pin_clk),
   .arst_n    (arst_n),
   .pin_c1    (pin_c1),
   .pin_c4    (pin_c4),
   .pin_cond  (pin_cond),
   .pin_mi    (pin_mi),
   .pin_inrrq (pin_inrrq),
   .pin_bbusy (pin_bbusy),
   .pin_sr_n  (pin_sr_n),
   .pin_ra    (pin_ra),
   .pin_lc    (pin_lc),
   .pin_nop   (pin_nop),
   .pin_bus   (pin_bus)
);

`include "mcp_control_tb_util.svh"

initial
begin
   pin_clk = 1'b0;
   forever #4 pin_clk = ~pin_clk;            // 8 ns period
end

// one clock with the strobes moved on its falling edge
task automatic step_cycle();
   @(negedge pin_clk);
   phase  = (phase + 1) % 4;
   pin_c1 = (phase == 0);
   pin_c4 = (phase == 2);                    // two cycles after c1
endtask

// lands on the falling edge just before a tick
task automatic next_tick_edge();
   for (int k = 0; k < 4; k++)
   begin
      step_cycle();
      if (phase == 0)
         break;
   end
endtask

initial
begin
   int                 hold_n;
   mcp_pkg::mcp_addr_t hold_lc;
   string              tag;
   arst_n    = 1'b0;
   pin_c1    = 1'b0;
   pin_c4    = 1'b0;
   pin_cond  = 1'b0;
   pin_mi    = '0;
   pin_inrrq = '0;
   pin_bbusy = 1'b0;
   pin_sr_n  = 1'b1;
   pin_ra    = 1'b1;
   lfsr      = SEED;
   phase     = 0;
   for (int c = 0; c < 16; c++)
      step_cycle();
   arst_n = 1'b1;
   compare_addr("reset lc", `MCP_RESET_ADDR, pin_lc);   // reset latch forces start
   compare_bit("reset nop", 1'b1, pin_nop);
   compare_bus("reset bus", '0, pin_bus);

   for (int i = 0; i < N_ROWS; i++)
   begin
      pin_mi = ROWS[i].mi;                   // taken on the coming tick
      step_cycle();
      pin_cond  = ROWS[i].cond;
      pin_ra    = ROWS[i].ra;
      pin_bbusy = ROWS[i].bbusy;
      pin_inrrq = ROWS[i].rq;
      pin_sr_n  = ROWS[i].srn;
      if (ROWS[i].wk != WK_NONE)
      begin
         hold_lc = ROWS[i - 1].exp_lc;       // counter frozen here
         draw_hold(hold_n);
         if (ROWS[i].wk == WK_READY)
            pin_ra = 1'b0;
         else
            pin_bbusy = 1'b1;
         for (int t = 0; t < hold_n; t++)
         begin
            next_tick_edge();
            tag = $sformatf("row %0d hold", i);
            compare_addr(tag, hold_lc, pin_lc);
            compare_bit({tag, " wi"}, 1'b1, pin_bus.wi);
            step_cycle();
         end
         pin_ra    = ROWS[i].ra;             // release
         pin_bbusy = ROWS[i].bbusy;
         wait_wi_low(i);
      end
      next_tick_edge();
      tag = $sformatf("row %0d", i);
      compare_addr({tag, " lc"}, ROWS[i].exp_lc, pin_lc);
      compare_bit({tag, " nop"}, ROWS[i].exp_nop, pin_nop);
      compare_bus({tag, " bus"}, ROWS[i].exp_bus, pin_bus);
   end
   $display("Testbench passed");
   $finish;
end

endmodule

// ==== design/mcp_bus_ctl.sv ====
`timescale 1ns/1ps

module mcp_bus_ctl
(
   input  logic               pin_clk,
   input  logic               arst_n,
   input  logic               c1,        // phase 1 tick
   input  logic               c4,        // phase 4, byte strobe
   input  mcp_pkg::mcp_ctl_t  ctl,
   input  logic               sr,        // system reset latch
   input  logic               bbusy,     // bus busy pin
   input  logic               ra,        // ready pin
   output mcp_pkg::mcp_bus_t  bus,
   output logic               stall      // hold counter and mir
);

logic syn;
logic di;
logic di_set;     // read started, di follows syn
logic dout;
logic inrak;
logic wrby;
logic wi;
logic start_go;   // start accepted, bus free
logic end_go;     // end accepted, slave ready

assign start_go = (ctl.bus_rd | ctl.bus_wr) & ~bbusy;
assign end_go   = ctl.bus_end & ra;

// wait on busy at start, or no ready at end
assign wi = ~sr & (((ctl.bus_rd | ctl.bus_wr) & bbusy) | (ctl.bus_end & ~ra));

assign stall = wi;

always_ff @(posedge pin_clk or negedge arst_n)
begin
   if (!arst_n)
   begin
      syn    <= 1'b0;
      di     <= 1'b0;
      di_set <= 1'b0;
      dout   <= 1'b0;
      inrak  <= 1'b0;
   end
   else if (c1)
   begin
      di_set <= ~sr & ctl.bus_rd & ~bbusy & ~syn;
      syn    <= ~sr & (syn | start_go) & ~end_go;
      di     <= ~sr & (di | (syn & di_set)) & ~ctl.bus_end;   // one tick after syn
      dout   <= ~sr & (dout | (ctl.bus_wr & ~bbusy)) & ~ctl.bus_end;
      inrak  <= ~sr & (inrak | ctl.bus_iack) & ~end_go;        // up to cycle end
   end
end

// byte write strobe on the later phase
always_ff @(posedge pin_clk or negedge arst_n)
begin
   if (!arst_n)
      wrby <= 1'b0;
   else if (c4)
   begin
      if (sr || end_go)
         wrby <= 1'b0;
      else if (ctl.bus_byte && !bbusy)
         wrby <= 1'b1;
   end
end

always_comb
begin
   bus.syn   = syn;
   bus.di    = di;
   bus.dout  = dout & syn;                   // only while cycle active
   bus.inrak = inrak;
   bus.wrby  = wrby;
   bus.wi    = wi;
end

endmodule

// ==== design/mcp_control.sv ====
`timescale 1ns/1ps
`include "mcp_params.svh"

module mcp_control
(
   input  logic                    pin_clk,
   input  logic                    arst_n,
   input  logic                    pin_c1,      // phase 1 strobe
   input  logic                    pin_c4,      // phase 4 strobe
   input  logic                    pin_cond,    // branch condition
   input  logic [`MCP_MI_W-1:0]    pin_mi,      // microinstruction bus
   input  logic [4:1]              pin_inrrq,   // interrupt requests
   input  logic                    pin_bbusy,   // bus busy
   input  logic                    pin_sr_n,    // system reset
   input  logic                    pin_ra,      // ready
   output mcp_pkg::mcp_addr_t      pin_lc,      // next fetch address
   output logic                    pin_nop,     // nop during reset
   output mcp_pkg::mcp_bus_t       pin_bus
);

mcp_pkg::mcp_mi_t    mi;
mcp_pkg::mcp_ctl_t   ctl;
mcp_pkg::mcp_addr_t  pta;
logic [`MCP_TR_W-1:0] tr;
logic [2:0]          ts;
logic [2:0]          tsr_next;
logic [7:1]          irq;
logic                rni;
logic                sr;
logic                taken;
logic                ltsr;
logic                stall;

mcp_decode i_mcp_decode
(
   .mi       (mi),
   .cond     (pin_cond),
   .stall    (stall),
   .sr       (sr),
   .ctl      (ctl)
);

mcp_translate i_mcp_translate
(
   .rni      (rni),
   .tr       (tr),
   .ts       (ts),
   .irq      (irq),
   .pta      (pta),
   .taken    (taken),
   .tsr_next (tsr_next),
   .ltsr     (ltsr)
);

mcp_sequencer i_mcp_sequencer
(
   .pin_clk  (pin_clk),
   .arst_n   (arst_n),
   .c1       (pin_c1),
   .mi_in    (pin_mi),
   .sr_n     (pin_sr_n),
   .inrrq    (pin_inrrq),
   .ctl      (ctl),
   .pta      (pta),
   .taken    (taken),
   .tsr_next (tsr_next),
   .ltsr     (ltsr),
   .mi       (mi),
   .tr       (tr),
   .ts       (ts),
   .irq      (irq),
   .rni      (rni),
   .sr       (sr),
   .lc_next  (pin_lc)
);

mcp_bus_ctl i_mcp_bus_ctl
(
   .pin_clk  (pin_clk),
   .arst_n   (arst_n),
   .c1       (pin_c1),
   .c4       (pin_c4),
   .ctl      (ctl),
   .sr       (sr),
   .bbusy    (pin_bbusy),
   .ra       (pin_ra),
   .bus      (pin_bus),
   .stall    (stall)
);

assign pin_nop = sr;

endmodule

// ==== design/mcp_decode.sv ====
`timescale 1ns/1ps

module mcp_decode
(
   input  mcp_pkg::mcp_mi_t   mi,      // held microinstruction
   input  logic               cond,    // branch condition pin
   input  logic               stall,   // bus wait
   input  logic               sr,      // system reset latch
   output mcp_pkg::mcp_ctl_t  ctl
);

always_comb
begin
   ctl = '0;
   ctl.flag_sel = mi.field[2:0];             // flag index 5..7
   if (sr)
   begin
      // only the reset path runs, counter forced in sequencer
      ctl.sel_hold = 1'b1;
      ctl.ld_mi    = 1'b1;                   // fetch at reset address
   end
   else
   begin
      // bus requests stay visible while waiting
      case (mi.op)
         mcp_pkg::READ:       ctl.bus_rd   = 1'b1;
         mcp_pkg::WRITE:      ctl.bus_wr   = 1'b1;
         mcp_pkg::WRITE_BYTE:
         begin
            ctl.bus_wr   = 1'b1;
            ctl.bus_byte = 1'b1;
         end
         mcp_pkg::IACK:       ctl.bus_iack = 1'b1;
         mcp_pkg::END_CYCLE:  ctl.bus_end  = 1'b1;
         default:             ctl.bus_rd   = 1'b0;
      endcase

      if (stall)
         ctl.sel_hold = 1'b1;                // freeze counter and mir
      else
      begin
         ctl.ld_mi = 1'b1;
         ctl.ld_rr = mi.call;                // return = lc + 1
         case (mi.op)
            mcp_pkg::JUMP:       ctl.sel_jhi = 1'b1;
            mcp_pkg::JUMP_LOW:
            begin
               ctl.sel_jlo = cond;           // low byte when taken
               ctl.sel_inc = ~cond;
            end
            mcp_pkg::RETURN:     ctl.sel_ret = 1'b1;
            mcp_pkg::LOAD_TR:
            begin
               ctl.ld_tr   = 1'b1;           // word from mi bus
               ctl.sel_inc = 1'b1;
            end
            mcp_pkg::DISPATCH:
            begin
               ctl.sel_tra = 1'b1;           // increments if rni clear
               ctl.ld_ts   = 1'b1;
            end
            mcp_pkg::CLR_STATUS:
            begin
               ctl.clr_ts  = 1'b1;
               ctl.sel_inc = 1'b1;
            end
            mcp_pkg::SET_FLAG:
            begin
               ctl.flag_set = 1'b1;
               ctl.sel_inc  = 1'b1;
            end
            mcp_pkg::CLR_FLAG:
            begin
               ctl.flag_clr = 1'b1;
               ctl.sel_inc  = 1'b1;
            end
            default:             ctl.sel_inc = 1'b1;   // NEXT and bus ops
         endcase
      end
   end
end

endmodule

// ==== design/mcp_params.svh ====
`ifndef MCP_PARAMS_SVH
`define MCP_PARAMS_SVH

// location counter and microinstruction widths
`define MCP_ADDR_W         11
`define MCP_MI_W           18
`define MCP_FIELD_W        12          // address or flag select field
`define MCP_TR_W           16          // translation register

// first microinstruction after system reset
`define MCP_RESET_ADDR     11'h001

// upper five address bits of the macro dispatch table
`define MCP_DISPATCH_BASE  5'b11000

// vector table, two words per request level
`define MCP_VECTOR_BASE    11'h010

`endif

// ==== design/mcp_pkg.sv ====
`include "mcp_params.svh"

package mcp_pkg;

   typedef logic [`MCP_ADDR_W-1:0] mcp_addr_t;    // microprogram address

   typedef enum logic [3:0]
   {
      NEXT        = 4'h0,     // increment
      JUMP        = 4'h1,     // load all 11 bits
      JUMP_LOW    = 4'h2,     // low 8 bits on cond
      RETURN      = 4'h3,     // from return register
      LOAD_TR     = 4'h4,     // translation register load
      DISPATCH    = 4'h5,     // macro dispatch or vector
      CLR_STATUS  = 4'h6,
      SET_FLAG    = 4'h7,     // internal request 5..7
      CLR_FLAG    = 4'h8,
      READ        = 4'h9,     // bus read start
      WRITE       = 4'ha,     // bus write start
      WRITE_BYTE  = 4'hb,
      IACK        = 4'hc,     // interrupt acknowledge
      END_CYCLE   = 4'hd      // wait for ready, end bus cycle
   } mcp_op_e;

   typedef struct packed
   {
      logic                     rni;     // read next instruction
      logic                     call;    // store return address
      mcp_op_e                  op;
      logic [`MCP_FIELD_W-1:0]  field;   // target or flag select
   } mcp_mi_t;

   typedef struct packed
   {
      logic       sel_hold;   // counter sources, one-hot
      logic       sel_inc;
      logic       sel_jlo;
      logic       sel_jhi;
      logic       sel_tra;
      logic       sel_ret;
      logic       ld_mi;      // register loads
      logic       ld_tr;
      logic       ld_rr;
      logic       clr_ts;     // translation status
      logic       ld_ts;
      logic       flag_set;   // internal request flags
      logic       flag_clr;
      logic [2:0] flag_sel;
      logic       bus_rd;     // bus cycle requests
      logic       bus_wr;
      logic       bus_end;
      logic       bus_byte;
      logic       bus_iack;
   } mcp_ctl_t;

   typedef struct packed
   {
      logic syn;     // cycle sync
      logic di;      // data in strobe
      logic dout;    // data out, gated by syn
      logic inrak;   // interrupt ack
      logic wrby;    // write byte
      logic wi;      // wait
   } mcp_bus_t;

endpackage

// ==== design/mcp_sequencer.sv ====
`timescale 1ns/1ps
`include "mcp_params.svh"

module mcp_sequencer
(
   input  logic                    pin_clk,
   input  logic                    arst_n,
   input  logic                    c1,         // phase 1 tick
   input  logic [`MCP_MI_W-1:0]    mi_in,      // microinstruction pins
   input  logic                    sr_n,       // system reset pin
   input  logic [4:1]              inrrq,      // external requests
   input  mcp_pkg::mcp_ctl_t       ctl,
   input  mcp_pkg::mcp_addr_t      pta,
   input  logic                    taken,
   input  logic [2:0]              tsr_next,
   input  logic                    ltsr,
   output mcp_pkg::mcp_mi_t        mi,         // instruction register
   output logic [`MCP_TR_W-1:0]    tr,         // translation register
   output logic [2:0]              ts,         // translation status
   output logic [7:1]              irq,        // request latches
   output logic                    rni,
   output logic                    sr,         // reset latch, also nop
   output mcp_pkg::mcp_addr_t      lc_next     // next counter value
);

mcp_pkg::mcp_addr_t  lc;         // location counter
mcp_pkg::mcp_addr_t  lc_inc;
mcp_pkg::mcp_addr_t  rr;         // return register
mcp_pkg::mcp_addr_t  jlo_addr;   // low byte replaced
logic                use_inc;    // increment, or dispatch not taken
logic                use_tra;

assign lc_inc   = lc + mcp_pkg::mcp_addr_t'(1);
assign jlo_addr = {lc[`MCP_ADDR_W-1:8], mi.field[7:0]};
assign use_tra  = ctl.sel_tra & taken;
assign use_inc  = ctl.sel_inc | (ctl.sel_tra & ~taken);

// or-mux over one-hot sources, reset overrides
always_comb
begin
   if (sr)
      lc_next = `MCP_RESET_ADDR;
   else
      lc_next = ({`MCP_ADDR_W{ctl.sel_hold}} & lc)
              | ({`MCP_ADDR_W{use_inc}}      & lc_inc)
              | ({`MCP_ADDR_W{ctl.sel_jlo}}  & jlo_addr)
              | ({`MCP_ADDR_W{ctl.sel_jhi}}  & mi.field[`MCP_ADDR_W-1:0])
              | ({`MCP_ADDR_W{use_tra}}      & pta)
              | ({`MCP_ADDR_W{ctl.sel_ret}}  & rr);
end

assign rni = mi.rni;

// control state
always_ff @(posedge pin_clk or negedge arst_n)
begin
   if (!arst_n)
   begin
      sr  <= 1'b1;                           // power up as system reset
      lc  <= `MCP_RESET_ADDR;
      mi  <= '0;
      ts  <= 3'd0;
      irq <= '0;
   end
   else if (c1)
   begin
      sr <= ~sr_n;
      lc <= lc_next;
      if (ctl.ld_mi)
         mi <= mcp_pkg::mcp_mi_t'(mi_in);
      if (ctl.clr_ts)
         ts <= 3'd0;
      else if (ctl.ld_ts && ltsr)
         ts <= tsr_next;                     // level now in service
      irq[4:1] <= inrrq;                     // sampled every tick
      for (int i = 5; i <= 7; i++)
      begin
         if (ctl.flag_set && (ctl.flag_sel == 3'(i)))
            irq[i] <= 1'b1;
         else if (ctl.flag_clr && (ctl.flag_sel == 3'(i)))
            irq[i] <= 1'b0;
      end
   end
end

// payload registers
always_ff @(posedge pin_clk)
begin
   if (c1)
   begin
      if (ctl.ld_rr)
         rr <= lc_inc;                       // resume after the call
      if (ctl.ld_tr)
         tr <= mi_in[`MCP_TR_W-1:0];         // macro word from mi pins
   end
end

endmodule

// ==== design/mcp_translate.sv ====
`timescale 1ns/1ps
`include "mcp_params.svh"

module mcp_translate
(
   input  logic                    rni,        // read next instruction
   input  logic [`MCP_TR_W-1:0]    tr,         // translation register
   input  logic [2:0]              ts,         // current status level
   input  logic [7:1]              irq,        // latched requests
   output mcp_pkg::mcp_addr_t      pta,        // translated address
   output logic                    taken,      // translation used
   output logic [2:0]              tsr_next,   // level of taken vector
   output logic                    ltsr        // status load
);

logic [2:0]          idx;        // highest pending level
logic                pending;    // request above status
mcp_pkg::mcp_addr_t  vec_off;    // two words per vector
mcp_pkg::mcp_addr_t  disp_addr;  // macro handler entry

// priority encoder, higher index wins
always_comb
begin
   idx = 3'd0;
   for (int i = 1; i <= 7; i++)
   begin
      if (irq[i] && (3'(i) > ts))    // masked at or below status
         idx = 3'(i);
   end
end

assign pending = (idx != 3'd0);

assign vec_off   = mcp_pkg::mcp_addr_t'({idx, 1'b0});
assign disp_addr = {`MCP_DISPATCH_BASE, tr[`MCP_TR_W-1:`MCP_TR_W-6]};   // opcode bits

always_comb
begin
   if (pending)
      pta = `MCP_VECTOR_BASE + vec_off;       // interrupt vector
   else
      pta = disp_addr;
end

// dispatch only with a fresh macro word
assign taken = rni;

// status remembers which vector went out
assign tsr_next = idx;
assign ltsr     = rni & pending;

endmodule
